// ==== logic/scene_pkg.sv ====
`default_nettype none

package scene_pkg;

    // Raw instruction layout: {op[31:29], index[28:24], data[23:0]}
    localparam int INSTR_WIDTH = 32;                // Host instruction word
    localparam int OP_WIDTH    = 3;                 // Opcode field
    localparam int INDEX_WIDTH = 5;                 // Index field
    localparam int WORD_WIDTH  = 24;                // Scene data word

    localparam int OP_LSB      = INSTR_WIDTH - OP_WIDTH;  // Bottom bit of opcode
    localparam int INDEX_LSB   = WORD_WIDTH;              // Bottom bit of index

    localparam int CAMERA_FIELDS = 4;               // pos_x, pos_y, pos_z, fov

    localparam int DEFAULT_LIGHT_DEPTH = 4;         // Light table entries
    localparam int DEFAULT_GEO_DEPTH   = 32;        // Geometry table entries

    // Codes 5 to 7 are illegal, decode turns them into OP_NOP
    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP      = 3'd0,                         // Retires, no state change
        OP_CAMERA   = 3'd1,                         // Write one camera field
        OP_LIGHT    = 3'd2,                         // Write one light entry
        OP_GEOMETRY = 3'd3,                         // Write one geometry entry
        OP_COMMIT   = 3'd4                          // Mark scene ready
    } op_e;

    // Same bit order as the raw word, 32 bits
    typedef struct packed {
        op_e                    op;                 // Legal opcode only
        logic [INDEX_WIDTH-1:0] index;              // Camera field or table slot
        logic [WORD_WIDTH-1:0]  data;               // Value to store
    } decoded_inst_t;

    // Camera index 0 to 3 picks the field in this order, 96 bits
    typedef struct packed {
        logic [WORD_WIDTH-1:0] pos_x;               // Index 0
        logic [WORD_WIDTH-1:0] pos_y;               // Index 1
        logic [WORD_WIDTH-1:0] pos_z;               // Index 2
        logic [WORD_WIDTH-1:0] fov;                 // Index 3
    } camera_t;

endpackage

`default_nettype wire

// ==== logic/inst_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_decode
    import scene_pkg::*;
(
    input  wire                   clk_50mhz,
    input  wire                   rst,
    input  wire                   instr_valid,  // Host strobe, no back-pressure
    input  wire [INSTR_WIDTH-1:0] instr,        // Raw scene instruction
    output logic                  dinst_valid,  // One cycle after instr_valid
    output decoded_inst_t         dinst         // Registered fields
);

    logic [OP_WIDTH-1:0]    raw_op;             // Opcode as sent by host
    logic [INDEX_WIDTH-1:0] raw_index;          // Index field
    logic [WORD_WIDTH-1:0]  raw_data;           // Data field
    op_e                    legal_op;           // Opcode after illegal-code filter

    assign raw_op    = instr[INSTR_WIDTH-1:OP_LSB];   // Top 3 bits
    assign raw_index = instr[OP_LSB-1:INDEX_LSB];     // Next 5 bits
    assign raw_data  = instr[WORD_WIDTH-1:0];         // Low 24 bits

    // Known codes pass, anything else becomes a no-op
    always_comb begin
        case (raw_op)
            OP_CAMERA: begin
                legal_op = OP_CAMERA;
            end
            OP_LIGHT: begin
                legal_op = OP_LIGHT;
            end
            OP_GEOMETRY: begin
                legal_op = OP_GEOMETRY;
            end
            OP_COMMIT: begin
                legal_op = OP_COMMIT;
            end
            default: begin
                legal_op = OP_NOP;                    // Includes codes 5 to 7
            end
        endcase
    end

    // Valid flag is control state
    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            dinst_valid <= 1'b0;
        end else begin
            dinst_valid <= instr_valid;               // Follows the stream 1:1
        end
    end

    // Fields only load on a real instruction
    always_ff @(posedge clk_50mhz) begin
        if (instr_valid) begin
            dinst.op    <= legal_op;
            dinst.index <= raw_index;
            dinst.data  <= raw_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/execute.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute
    import scene_pkg::*;
#(
    parameter int LIGHT_DEPTH = DEFAULT_LIGHT_DEPTH,
    parameter int GEO_DEPTH   = DEFAULT_GEO_DEPTH
) (
    input  wire                             clk_50mhz,
    input  wire                             rst,
    input  wire                             dinst_valid,     // From decode
    input  wire decoded_inst_t              dinst,
    input  wire [$clog2(LIGHT_DEPTH)-1:0]   light_read_addr, // Render side
    input  wire [$clog2(GEO_DEPTH)-1:0]     geo_read_addr,
    output logic                            inst_done,       // Retire strobe
    output op_e                             inst_done_op,    // Retired opcode
    output logic                            memory_ready,    // Scene committed
    output camera_t                         cur_camera,
    output logic [WORD_WIDTH-1:0]           cur_light,       // Two cycles after addr
    output logic [WORD_WIDTH-1:0]           cur_geo
);

    logic          buf_valid;                   // Buffered valid flag
    decoded_inst_t buf_inst;                    // Buffered instruction

    // Single-entry buffer between decode and the bank
    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else begin
            buf_valid <= dinst_valid;
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (dinst_valid) begin
            buf_inst <= dinst;                  // Hold payload for the write stage
        end
    end

    memory_bank #(
        .LIGHT_DEPTH (LIGHT_DEPTH),
        .GEO_DEPTH   (GEO_DEPTH)
    ) u_memory_bank (
        .clk_50mhz       (clk_50mhz),
        .rst             (rst),
        .buf_valid       (buf_valid),
        .buf_inst        (buf_inst),
        .light_read_addr (light_read_addr),
        .geo_read_addr   (geo_read_addr),
        .done_valid      (inst_done),
        .done_op         (inst_done_op),
        .ready           (memory_ready),
        .camera          (cur_camera),
        .light_data      (cur_light),
        .geo_data        (cur_geo)
    );

endmodule

`default_nettype wire

// ==== logic/memory_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module memory_bank
    import scene_pkg::*;
#(
    parameter int LIGHT_DEPTH = DEFAULT_LIGHT_DEPTH,
    parameter int GEO_DEPTH   = DEFAULT_GEO_DEPTH
) (
    input  wire                             clk_50mhz,
    input  wire                             rst,
    input  wire                             buf_valid,       // Write this cycle
    input  wire decoded_inst_t              buf_inst,
    input  wire [$clog2(LIGHT_DEPTH)-1:0]   light_read_addr,
    input  wire [$clog2(GEO_DEPTH)-1:0]     geo_read_addr,
    output logic                            done_valid,      // Retire pulse
    output op_e                             done_op,
    output logic                            ready,           // Set by commit
    output camera_t                         camera,          // Live camera record
    output logic [WORD_WIDTH-1:0]           light_data,
    output logic [WORD_WIDTH-1:0]           geo_data
);

    localparam int LIGHT_AW = $clog2(LIGHT_DEPTH); // Light table address bits
    localparam int GEO_AW   = $clog2(GEO_DEPTH);   // Geometry table address bits

    logic [WORD_WIDTH-1:0] light_table [LIGHT_DEPTH];
    logic [WORD_WIDTH-1:0] geo_table   [GEO_DEPTH];

    logic [LIGHT_AW-1:0]   light_addr_q;        // Read stage 1
    logic [GEO_AW-1:0]     geo_addr_q;
    logic                  is_write;            // Any op that edits the scene

    // Table slot comes from the low bits of the index
    assign is_write = (buf_inst.op == OP_CAMERA) || (buf_inst.op == OP_LIGHT) ||
                      (buf_inst.op == OP_GEOMETRY);

    // Camera record, cleared on reset
    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            camera <= '0;
        end else if (buf_valid && buf_inst.op == OP_CAMERA &&
                     buf_inst.index < INDEX_WIDTH'(CAMERA_FIELDS)) begin
            case (buf_inst.index)
                INDEX_WIDTH'(0): camera.pos_x <= buf_inst.data;
                INDEX_WIDTH'(1): camera.pos_y <= buf_inst.data;
                INDEX_WIDTH'(2): camera.pos_z <= buf_inst.data;
                default:         camera.fov   <= buf_inst.data;  // Index 3
            endcase
        end
    end

    // Scene tables start out zero
    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            for (int i = 0; i < LIGHT_DEPTH; i++) begin
                light_table[i] <= '0;
            end
        end else if (buf_valid && buf_inst.op == OP_LIGHT) begin
            light_table[buf_inst.index[LIGHT_AW-1:0]] <= buf_inst.data;
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            for (int i = 0; i < GEO_DEPTH; i++) begin
                geo_table[i] <= '0;
            end
        end else if (buf_valid && buf_inst.op == OP_GEOMETRY) begin
            geo_table[buf_inst.index[GEO_AW-1:0]] <= buf_inst.data;
        end
    end

    // Commit sets, any scene write clears, NOP holds
    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            ready      <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= buf_valid;            // Every valid op retires
            if (buf_valid && buf_inst.op == OP_COMMIT) begin
                ready <= 1'b1;
            end else if (buf_valid && is_write) begin
                ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (buf_valid) begin
            done_op <= buf_inst.op;             // Only meaningful with done_valid
        end
    end

    // Address register then data register, two cycles total
    always_ff @(posedge clk_50mhz) begin
        light_addr_q <= light_read_addr;
        geo_addr_q   <= geo_read_addr;
        light_data   <= light_table[light_addr_q];  // Sees writes up to the address edge
        geo_data     <= geo_table[geo_addr_q];
    end

endmodule

`default_nettype wire

// ==== logic/scene_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module scene_core
    import scene_pkg::*;
#(
    parameter int LIGHT_DEPTH = DEFAULT_LIGHT_DEPTH,  // Light table size
    parameter int GEO_DEPTH   = DEFAULT_GEO_DEPTH     // Geometry table size
) (
    input  wire                             clk_50mhz,
    input  wire                             rst,
    input  wire                             instr_valid,     // One instruction per cycle max
    input  wire [INSTR_WIDTH-1:0]           instr,
    input  wire [$clog2(LIGHT_DEPTH)-1:0]   light_read_addr,
    input  wire [$clog2(GEO_DEPTH)-1:0]     geo_read_addr,
    output logic                            inst_done,       // Three cycles after instr_valid
    output op_e                             inst_done_op,
    output logic                            memory_ready,
    output camera_t                         cur_camera,
    output logic [WORD_WIDTH-1:0]           cur_light,
    output logic [WORD_WIDTH-1:0]           cur_geo
);

    logic          dinst_valid;                 // Decode to execute
    decoded_inst_t dinst;

    inst_decode u_inst_decode (
        .clk_50mhz   (clk_50mhz),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dinst_valid (dinst_valid),
        .dinst       (dinst)
    );

    // Depths flow down from here
    execute #(
        .LIGHT_DEPTH (LIGHT_DEPTH),
        .GEO_DEPTH   (GEO_DEPTH)
    ) u_execute (
        .clk_50mhz       (clk_50mhz),
        .rst             (rst),
        .dinst_valid     (dinst_valid),
        .dinst           (dinst),
        .light_read_addr (light_read_addr),
        .geo_read_addr   (geo_read_addr),
        .inst_done       (inst_done),
        .inst_done_op    (inst_done_op),
        .memory_ready    (memory_ready),
        .cur_camera      (cur_camera),
        .cur_light       (cur_light),
        .cur_geo         (cur_geo)
    );

endmodule

`default_nettype wire

// ==== bench/scene_model.svh ====
`ifndef SCENE_MODEL_SVH
`define SCENE_MODEL_SVH

typedef struct packed {
    logic          valid;                       // Slot held a real instruction
    decoded_inst_t inst;
} slot_t;

slot_t                 pend [$];                // In flight, oldest first, one slot per cycle
camera_t               model_camera;
logic [WORD_WIDTH-1:0] model_light [LIGHT_DEPTH];
logic [WORD_WIDTH-1:0] model_geo   [GEO_DEPTH];
logic                  model_ready;
logic [WORD_WIDTH-1:0] light_pipe  [2];         // Entry 1 is on the read port
logic [WORD_WIDTH-1:0] geo_pipe    [2];
logic                  exp_done;                // Expected after the latest edge
op_e                   exp_op;
logic [WORD_WIDTH-1:0] exp_light;
logic [WORD_WIDTH-1:0] exp_geo;

// Codes above OP_COMMIT are illegal
function automatic op_e decode_opcode(input logic [2:0] code);
    if (code > 3'd4) begin
        return OP_NOP;
    end
    return op_e'(code);
endfunction

task automatic reset_model();
    pend.delete();
    repeat (2) begin
        pend.push_back('0);                     // Decode and buffer idle
    end
    model_camera = '0;
    model_ready  = 1'b0;
    for (int i = 0; i < LIGHT_DEPTH; i++) begin
        model_light[i] = '0;
    end
    for (int i = 0; i < GEO_DEPTH; i++) begin
        model_geo[i] = '0;
    end
    light_pipe = '{default: '0};
    geo_pipe   = '{default: '0};
    exp_done   = 1'b0;
    exp_op     = OP_NOP;
endtask

task automatic retire_into_model(input decoded_inst_t inst);
    case (inst.op)
        OP_CAMERA: begin
            case (inst.index)
                5'd0: model_camera.pos_x = inst.data;
                5'd1: model_camera.pos_y = inst.data;
                5'd2: model_camera.pos_z = inst.data;
                5'd3: model_camera.fov   = inst.data;
                default: ;                      // No such field
            endcase
            model_ready = 1'b0;                 // Cleared even by an ignored field
        end
        OP_LIGHT: begin
            model_light[inst.index[LIGHT_AW-1:0]] = inst.data;
            model_ready = 1'b0;
        end
        OP_GEOMETRY: begin
            model_geo[inst.index[GEO_AW-1:0]] = inst.data;
            model_ready = 1'b0;
        end
        OP_COMMIT: model_ready = 1'b1;
        default: ;                              // NOP retires only
    endcase
endtask

// One rising edge, given the inputs the DUT samples there
task automatic advance_model(input logic valid, input logic [INSTR_WIDTH-1:0] raw,
                             input logic [LIGHT_AW-1:0] l_addr,
                             input logic [GEO_AW-1:0] g_addr);
    slot_t done_slot;
    slot_t new_slot;
    new_slot.valid      = valid;
    new_slot.inst.op    = decode_opcode(raw[31:29]);
    new_slot.inst.index = raw[28:24];
    new_slot.inst.data  = raw[23:0];
    pend.push_back(new_slot);                   // Three deep until the oldest leaves
    done_slot = pend.pop_front();               // Sampled two edges ago
    exp_done  = done_slot.valid;
    if (done_slot.valid) begin
        exp_op = done_slot.inst.op;
        retire_into_model(done_slot.inst);
    end
    light_pipe[1] = light_pipe[0];
    light_pipe[0] = model_light[l_addr];        // Includes the write at this edge
    exp_light     = light_pipe[1];
    geo_pipe[1]   = geo_pipe[0];
    geo_pipe[0]   = model_geo[g_addr];
    exp_geo       = geo_pipe[1];
endtask

`endif

// ==== bench/scene_core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module scene_core_tb
    import scene_pkg::*;
();

    localparam int LIGHT_DEPTH    = DEFAULT_LIGHT_DEPTH;
    localparam int GEO_DEPTH      = DEFAULT_GEO_DEPTH;
    localparam int LIGHT_AW       = $clog2(LIGHT_DEPTH);
    localparam int GEO_AW         = $clog2(GEO_DEPTH);
    localparam int RESET_CYCLES   = 5;
    localparam int SWEEP_CYCLES   = GEO_DEPTH;  // Idle reads over every address
    localparam int RANDOM_CYCLES  = 1500;
    localparam int DRAIN_CYCLES   = 6;          // Lets the last writes and reads land
    localparam int TEST_CYCLES    = RESET_CYCLES + SWEEP_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

    logic                  clk_50mhz;
    logic                  rst;
    logic                  instr_valid;
    logic [INSTR_WIDTH-1:0] instr;
    logic [LIGHT_AW-1:0]   light_read_addr;
    logic [GEO_AW-1:0]     geo_read_addr;
    logic                  inst_done;
    op_e                   inst_done_op;
    logic                  memory_ready;
    camera_t               cur_camera;
    logic [WORD_WIDTH-1:0] cur_light;
    logic [WORD_WIDTH-1:0] cur_geo;

    integer      seed;
    logic [31:0] rand_ctl;                      // Valid, index bias and read addresses
    logic [31:0] rand_word;                     // Raw instruction
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    `include "scene_model.svh"

    scene_core #(
        .LIGHT_DEPTH (LIGHT_DEPTH),
        .GEO_DEPTH   (GEO_DEPTH)
    ) u_scene_core (
        .clk_50mhz       (clk_50mhz),
        .rst             (rst),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .light_read_addr (light_read_addr),
        .geo_read_addr   (geo_read_addr),
        .inst_done       (inst_done),
        .inst_done_op    (inst_done_op),
        .memory_ready    (memory_ready),
        .cur_camera      (cur_camera),
        .cur_light       (cur_light),
        .cur_geo         (cur_geo)
    );

    initial begin
        clk_50mhz = 1'b0;
        forever begin
            #10 clk_50mhz = ~clk_50mhz;         // 50 MHz
        end
    end

    task automatic check_bit(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_op(input string name, input op_e actual, input op_e expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_camera(input string name, input camera_t actual,
                                input camera_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_WIDTH-1:0] actual,
                              input logic [WORD_WIDTH-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_outputs();
        check_bit("inst_done", inst_done, exp_done);
        if (exp_done) begin
            check_op("inst_done_op", inst_done_op, exp_op);
        end
        check_camera("cur_camera", cur_camera, model_camera);
        check_word("cur_light", cur_light, exp_light);
        check_word("cur_geo", cur_geo, exp_geo);
        check_bit("memory_ready", memory_ready, model_ready);
    endtask

    // Model sees what the DUT samples, new inputs go out, outputs checked mid-cycle
    task automatic drive_cycle(input logic valid, input logic [INSTR_WIDTH-1:0] word,
                               input logic [LIGHT_AW-1:0] l_addr,
                               input logic [GEO_AW-1:0] g_addr);
        @(posedge clk_50mhz);
        advance_model(instr_valid, instr, light_read_addr, geo_read_addr);
        instr_valid     <= valid;
        instr           <= word;
        light_read_addr <= l_addr;
        geo_read_addr   <= g_addr;
        @(negedge clk_50mhz);
        compare_outputs();
    endtask

    initial begin
        seed            = 32'ha5bb;
        rst             <= 1'b1;
        instr_valid     <= 1'b0;
        instr           <= '0;
        light_read_addr <= '0;
        geo_read_addr   <= '0;
        reset_model();
        repeat (RESET_CYCLES) begin
            @(posedge clk_50mhz);
        end
        rst <= 1'b0;
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            drive_cycle(1'b0, '0, LIGHT_AW'(i), GEO_AW'(i));  // Light addresses wrap
        end
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rand_ctl  = $random(seed);
            rand_word = $random(seed);
            if (rand_ctl[2]) begin
                rand_word[28:27] = 2'b00;       // Small indices, reach camera fields
            end
            drive_cycle(rand_ctl[1:0] != 2'b00, rand_word,
                        rand_ctl[8 +: LIGHT_AW], rand_ctl[16 +: GEO_AW]);
        end
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            drive_cycle(1'b0, '0, '0, '0);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk_50mhz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== scene_core.f ====
+incdir+bench
logic/scene_pkg.sv
logic/inst_decode.sv
logic/execute.sv
logic/memory_bank.sv
logic/scene_core.sv
bench/scene_core_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := scene_core_tb
FILELIST := scene_core.f
OBJ_DIR  := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
